//--- Makefile
VERILATOR ?= verilator
TOP ?= rename_unit_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/checkpoint_store.sv
`include "rename_consts.svh"

module checkpoint_store
  import rename_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic      clock,
  input  logic      reset,
  input  payload_t  reset_value,
  input  logic      write,
  input  cp_index_t write_idx,
  input  payload_t  data_in,
  input  cp_index_t read_idx,
  output payload_t  data_out
);

  payload_t slots [`CP_COUNT];

  ////////////////////////////////////////////////////////////
  // Slot storage
  ////////////////////////////////////////////////////////////

  // Every slot starts out as the reset state, so an early
  // recover lands on a consistent image
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CP_COUNT; i++) begin
        slots[i] <= reset_value;
      end
    end else if (write) begin
      slots[write_idx] <= data_in;
    end
  end

  // Recover needs the image in the same cycle
  always_comb begin
    data_out = slots[read_idx];
  end

endmodule

//--- logic/free_list.sv
`include "rename_consts.svh"

module free_list
  import rename_pkg::*;
(
  input  logic                               clock,
  input  logic                               reset,
  input  logic [`RENAME_WIDTH-1:0]           alloc_req,
  input  release_t [`RENAME_WIDTH-1:0]       releases,
  input  logic                               check,
  input  cp_index_t                          check_idx,
  input  logic                               commit,
  input  logic                               recover,
  input  cp_index_t                          recover_idx,
  output prf_index_t [`RENAME_WIDTH-1:0]     alloc_prf,
  output logic                               allocatable
);

  prf_mask_t free_q;
  prf_mask_t free_next;
  prf_mask_t free_reset;
  prf_mask_t free_saved;
  prf_mask_t release_bits;
  prf_mask_t avail_second;
  prf_mask_t rel_mask_q [`CP_COUNT];

  logic found_first;
  logic found_second;
  prf_index_t first_idx;
  prf_index_t second_idx;

  // Lowest set bit of a mask
  function automatic void find_lowest(input prf_mask_t mask, output logic found,
                                      output prf_index_t idx);
    found = 1'b0;
    idx = '0;
    for (int i = `PRF_SIZE - 1; i >= 0; i--) begin
      if (mask[i]) begin
        found = 1'b1;
        idx = prf_index_t'(i);
      end
    end
  endfunction

  // Registers above the identity map start free
  always_comb begin
    for (int i = 0; i < `PRF_SIZE; i++) begin
      free_reset[i] = (i >= `ARF_SIZE);
    end
  end

  ////////////////////////////////////////////////////////////
  // Allocation
  ////////////////////////////////////////////////////////////

  always_comb begin
    find_lowest(free_q, found_first, first_idx);
    avail_second = free_q;
    avail_second[first_idx] = 1'b0;
    find_lowest(avail_second, found_second, second_idx);
    alloc_prf[0] = first_idx;
    // Lane 1 takes the lowest when lane 0 has no destination
    alloc_prf[1] = alloc_req[0] ? second_idx : first_idx;
    allocatable = found_first & found_second;
  end

  always_comb begin
    release_bits = '0;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (releases[i].valid) begin
        release_bits[releases[i].prf] = 1'b1;
      end
    end
    free_next = free_q;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (alloc_req[i]) begin
        free_next[alloc_prf[i]] = 1'b0;
      end
    end
    free_next = free_next | release_bits;
  end

  ////////////////////////////////////////////////////////////
  // State update and recovery
  ////////////////////////////////////////////////////////////

  // A slot's release mask holds what was freed after its save
  always_ff @(posedge clock) begin
    if (reset) begin
      free_q <= free_reset;
      for (int s = 0; s < `CP_COUNT; s++) begin
        rel_mask_q[s] <= '0;
      end
    end else if (recover) begin
      free_q <= free_saved | rel_mask_q[recover_idx];
    end else if (commit) begin
      free_q <= free_next;
      for (int s = 0; s < `CP_COUNT; s++) begin
        if (check && check_idx == cp_index_t'(s)) begin
          rel_mask_q[s] <= '0;
        end else begin
          rel_mask_q[s] <= rel_mask_q[s] | release_bits;
        end
      end
    end
  end

  checkpoint_store #(.payload_t(prf_mask_t)) free_cp_i (
    .clock       (clock),
    .reset       (reset),
    .reset_value (free_reset),
    .write       (check & commit),
    .write_idx   (check_idx),
    .data_in     (free_next),
    .read_idx    (recover_idx),
    .data_out    (free_saved)
  );

endmodule

//--- logic/map_table.sv
`include "rename_consts.svh"

module map_table
  import rename_pkg::*;
(
  input  logic                                clock,
  input  logic                                reset,
  input  rename_group_t                       group,
  input  release_t [`RENAME_WIDTH-1:0]        releases,
  input  logic                                recover,
  input  cp_index_t                           recover_idx,
  input  prf_index_t [`RENAME_WIDTH-1:0]      alloc_prf,
  output rename_result_t [`RENAME_WIDTH-1:0]  result,
  output logic                                result_valid,
  output logic [`RENAME_WIDTH-1:0]            alloc_req,
  output release_t [`RENAME_WIDTH-1:0]        release_latched,
  output logic                                check,
  output cp_index_t                           check_idx,
  output logic                                commit
);

  rename_group_t group_q;

  map_image_t map_q;
  map_image_t map_next;
  map_image_t map_reset;
  map_image_t map_saved;

  // Identity mapping, arch i on phys i
  always_comb begin
    for (int i = 0; i < `ARF_SIZE; i++) begin
      map_reset[i] = prf_index_t'(i);
    end
  end

  ////////////////////////////////////////////////////////////
  // Input group register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      group_q <= '0;
      release_latched <= '0;
    end else begin
      group_q <= group;
      release_latched <= releases;
    end
  end

  ////////////////////////////////////////////////////////////
  // Lane walk
  ////////////////////////////////////////////////////////////

  // Lanes in order, each one sees the writes of earlier lanes
  always_comb begin
    map_next = map_q;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      result[i].prs1 = map_next[group_q.lanes[i].rs1];
      result[i].prs2 = map_next[group_q.lanes[i].rs2];
      result[i].prd = '0;
      result[i].prev_rd = '0;
      if (group_q.lanes[i].rd_valid) begin
        // Mapping before this lane's own write
        result[i].prev_rd = map_next[group_q.lanes[i].rd];
        result[i].prd = alloc_prf[i];
        map_next[group_q.lanes[i].rd] = alloc_prf[i];
      end
    end
  end

  always_comb begin
    result_valid = group_q.check;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      alloc_req[i] = group_q.lanes[i].rd_valid;
      result_valid = result_valid | group_q.lanes[i].rd_valid;
    end
  end

  // A recover edge throws away the latched group
  assign commit = ~recover;
  assign check = group_q.check;
  assign check_idx = group_q.check_idx;

  ////////////////////////////////////////////////////////////
  // Map state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      map_q <= map_reset;
    end else if (recover) begin
      map_q <= map_saved;
    end else begin
      map_q <= map_next;
    end
  end

  // Snapshot includes this group's renames
  checkpoint_store #(.payload_t(map_image_t)) map_cp_i (
    .clock       (clock),
    .reset       (reset),
    .reset_value (map_reset),
    .write       (group_q.check & commit),
    .write_idx   (group_q.check_idx),
    .data_in     (map_next),
    .read_idx    (recover_idx),
    .data_out    (map_saved)
  );

endmodule

//--- logic/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

////////////////////////////////////////////////////////////
// Rename stage sizing
////////////////////////////////////////////////////////////

// Instructions renamed per cycle, also the number of release ports
`define RENAME_WIDTH 2

// Architectural integer registers
`define ARF_SIZE 32
`define ARF_INDEX_BITS 5

// Physical integer registers
`define PRF_SIZE 64
`define PRF_INDEX_BITS 6

// Branch checkpoint slots
`define CP_COUNT 4
`define CP_INDEX_BITS 2

`endif

//--- logic/rename_pkg.sv
`include "rename_consts.svh"

package rename_pkg;

  typedef logic [`ARF_INDEX_BITS-1:0] arf_index_t;
  typedef logic [`PRF_INDEX_BITS-1:0] prf_index_t;
  typedef logic [`CP_INDEX_BITS-1:0] cp_index_t;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // One instruction of a rename group
  typedef struct packed {
    logic rd_valid;
    arf_index_t rs1;
    arf_index_t rs2;
    arf_index_t rd;
  } rename_lane_t;

  // Present when any lane has a destination or check is set
  typedef struct packed {
    rename_lane_t [`RENAME_WIDTH-1:0] lanes;
    logic check;
    cp_index_t check_idx;
  } rename_group_t;

  ////////////////////////////////////////////////////////////
  // Answer side and state images
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    prf_index_t prs1;
    prf_index_t prs2;
    prf_index_t prd;
    prf_index_t prev_rd;
  } rename_result_t;

  // Register handed back at commit
  typedef struct packed {
    logic valid;
    prf_index_t prf;
  } release_t;

  typedef prf_index_t [`ARF_SIZE-1:0] map_image_t;
  typedef logic [`PRF_SIZE-1:0] prf_mask_t;

endpackage

//--- logic/rename_unit.sv
`include "rename_consts.svh"

module rename_unit
  import rename_pkg::*;
(
  input  logic                                clock,
  input  logic                                reset,
  input  rename_group_t                       group,
  input  release_t [`RENAME_WIDTH-1:0]        releases,
  input  logic                                recover,
  input  cp_index_t                           recover_idx,
  output rename_result_t [`RENAME_WIDTH-1:0]  result,
  output logic                                result_valid,
  output logic                                allocatable
);

  logic [`RENAME_WIDTH-1:0] alloc_req;
  prf_index_t [`RENAME_WIDTH-1:0] alloc_prf;
  release_t [`RENAME_WIDTH-1:0] release_latched;
  logic check;
  cp_index_t check_idx;
  logic commit;

  map_table map_table_i (
    .clock           (clock),
    .reset           (reset),
    .group           (group),
    .releases        (releases),
    .recover         (recover),
    .recover_idx     (recover_idx),
    .alloc_prf       (alloc_prf),
    .result          (result),
    .result_valid    (result_valid),
    .alloc_req       (alloc_req),
    .release_latched (release_latched),
    .check           (check),
    .check_idx       (check_idx),
    .commit          (commit)
  );

  // Works on the group latched by the map table
  free_list free_list_i (
    .clock       (clock),
    .reset       (reset),
    .alloc_req   (alloc_req),
    .releases    (release_latched),
    .check       (check),
    .check_idx   (check_idx),
    .commit      (commit),
    .recover     (recover),
    .recover_idx (recover_idx),
    .alloc_prf   (alloc_prf),
    .allocatable (allocatable)
  );

endmodule

//--- sim.f
+incdir+logic
logic/rename_pkg.sv
logic/checkpoint_store.sv
logic/free_list.sv
logic/map_table.sv
logic/rename_unit.sv
tests/rename_checker.sv
tests/rename_unit_tb.sv

//--- tests/rename_checker.sv
`include "rename_consts.svh"

module rename_checker
  import rename_pkg::*;
(
  input  logic                               clock,
  input  logic                               reset,
  input  rename_group_t                      group,
  input  release_t [`RENAME_WIDTH-1:0]       releases,
  input  logic                               recover,
  input  cp_index_t                          recover_idx,
  input  rename_result_t [`RENAME_WIDTH-1:0] result,
  input  logic                               result_valid,
  input  logic                               allocatable,
  output int                                 error_count,
  output int                                 check_count
);
  timeunit 1ns;
  timeprecision 1ps;

  map_image_t model_map;
  prf_mask_t model_free;
  map_image_t snap_map [`CP_COUNT];
  prf_mask_t snap_free [`CP_COUNT];
  prf_mask_t snap_rel [`CP_COUNT];
  rename_group_t held_group;
  release_t [`RENAME_WIDTH-1:0] held_rel;

  function automatic prf_index_t lowest_free(input prf_mask_t mask);
    for (int i = 0; i < `PRF_SIZE; i++) begin
      if (mask[i]) begin
        return prf_index_t'(i);
      end
    end
    return '0;
  endfunction

  task automatic compare(input string what, input int got, input int want);
    check_count++;
    if (got != want) begin
      error_count++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Model step, one per cycle on the falling edge
  ////////////////////////////////////////////////////////////

  // Model state is always the state after the last rising edge
  always @(negedge clock) begin
    map_image_t next_map;
    prf_mask_t work;
    prf_mask_t rel_bits;
    rename_lane_t lane;
    prf_index_t prd;
    logic present;
    if (reset) begin
      error_count = 0;
      check_count = 0;
      for (int a = 0; a < `ARF_SIZE; a++) begin
        model_map[a] = prf_index_t'(a);
      end
      for (int p = 0; p < `PRF_SIZE; p++) begin
        model_free[p] = (p >= `ARF_SIZE);
      end
      for (int s = 0; s < `CP_COUNT; s++) begin
        snap_map[s] = model_map;
        snap_free[s] = model_free;
        snap_rel[s] = '0;
      end
      held_group = '0;
      held_rel = '0;
    end else begin
      present = held_group.check;
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        present = present | held_group.lanes[i].rd_valid;
      end
      compare("allocatable", int'(allocatable), int'($countones(model_free) >= 2));
      compare("result_valid", int'(result_valid), int'(present));
      next_map = model_map;
      work = model_free;
      // Lane order, later lanes see earlier destinations
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        lane = held_group.lanes[i];
        if (present) begin
          compare($sformatf("lane %0d prs1", i), int'(result[i].prs1),
                  int'(next_map[lane.rs1]));
          compare($sformatf("lane %0d prs2", i), int'(result[i].prs2),
                  int'(next_map[lane.rs2]));
        end
        if (lane.rd_valid) begin
          if (work == '0) begin
            error_count++;
            $display("Destination issued with no free register at %0t", $time);
          end
          prd = lowest_free(work);
          work[prd] = 1'b0;
          compare($sformatf("lane %0d prd", i), int'(result[i].prd), int'(prd));
          compare($sformatf("lane %0d prev_rd", i), int'(result[i].prev_rd),
                  int'(next_map[lane.rd]));
          next_map[lane.rd] = prd;
        end
      end
      rel_bits = '0;
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        if (held_rel[i].valid) begin
          rel_bits[held_rel[i].prf] = 1'b1;
        end
      end
      if (recover) begin
        // Held group and its releases are dropped
        model_map = snap_map[recover_idx];
        model_free = snap_free[recover_idx] | snap_rel[recover_idx];
      end else begin
        model_map = next_map;
        model_free = work | rel_bits;
        for (int s = 0; s < `CP_COUNT; s++) begin
          if (held_group.check && held_group.check_idx == cp_index_t'(s)) begin
            snap_map[s] = model_map;
            snap_free[s] = model_free;
            snap_rel[s] = '0;
          end else begin
            snap_rel[s] = snap_rel[s] | rel_bits;
          end
        end
      end
      held_group = group;
      held_rel = releases;
    end
  end

endmodule

//--- tests/rename_unit_tb.sv
`include "rename_consts.svh"

module rename_unit_tb
  import rename_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 2;
  localparam int RUN_CYCLES = 2000;
  // Margin for the final drain cycles
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + RUN_CYCLES + 98;

  logic clock;
  logic reset;
  rename_group_t group;
  release_t [`RENAME_WIDTH-1:0] releases;
  logic recover;
  cp_index_t recover_idx;
  rename_result_t [`RENAME_WIDTH-1:0] result;
  logic result_valid;
  logic allocatable;
  int error_count;
  int check_count;
  int cycle_count;
  logic [31:0] lfsr;
  logic alloc_ok;
  rename_group_t in_flight;
  prf_index_t pending [$];

  rename_unit rename_unit_i (
    .clock        (clock),
    .reset        (reset),
    .group        (group),
    .releases     (releases),
    .recover      (recover),
    .recover_idx  (recover_idx),
    .result       (result),
    .result_valid (result_valid),
    .allocatable  (allocatable)
  );

  rename_checker rename_checker_i (
    .clock        (clock),
    .reset        (reset),
    .group        (group),
    .releases     (releases),
    .recover      (recover),
    .recover_idx  (recover_idx),
    .result       (result),
    .result_valid (result_valid),
    .allocatable  (allocatable),
    .error_count  (error_count),
    .check_count  (check_count)
  );

  always #5 clock = ~clock;

  ////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////

  // Galois form, one step per bit
  function automatic logic next_bit();
    logic out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [31:0] draw(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], next_bit()};
    end
    return value;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Replaced registers wait here until commit frees them
  task automatic collect_replaced();
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (result_valid && !recover && in_flight.lanes[i].rd_valid) begin
        pending.push_back(result[i].prev_rd);
      end
    end
  endtask

  task automatic drive_next();
    rename_group_t next;
    release_t [`RENAME_WIDTH-1:0] rel;
    next = '0;
    rel = '0;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      next.lanes[i].rd_valid = next_bit() & alloc_ok;
      next.lanes[i].rs1 = arf_index_t'(draw(`ARF_INDEX_BITS));
      next.lanes[i].rs2 = arf_index_t'(draw(`ARF_INDEX_BITS));
      next.lanes[i].rd = arf_index_t'(draw(`ARF_INDEX_BITS));
    end
    next.check = (draw(3) == 0);
    next.check_idx = cp_index_t'(draw(`CP_INDEX_BITS));
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (pending.size() > 0 && draw(2) != 0) begin
        rel[i].valid = 1'b1;
        rel[i].prf = pending.pop_front();
      end
    end
    // Current value is what this edge latches
    in_flight = group;
    group <= next;
    releases <= rel;
    recover <= (draw(4) == 0);
    recover_idx <= cp_index_t'(draw(`CP_INDEX_BITS));
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    group = '0;
    releases = '0;
    recover = 1'b0;
    recover_idx = '0;
    in_flight = '0;
    cycle_count = 0;
    lfsr = 32'h96ae;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    repeat (RUN_CYCLES) begin
      @(negedge clock);
      collect_replaced();
      alloc_ok = allocatable;
      @(posedge clock);
      drive_next();
    end
    repeat (2) @(posedge clock);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, stimulus did not finish", cycle_count);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule
